// ==== design/cc_pkg.sv ====
`default_nettype none

package cc_pkg;

	////////////////////
	// Widths
	////////////////////

	parameter int VERTEX_W   = 16;
	parameter int ADDR_W     = 16;
	parameter int LABEL_W    = 16;
	parameter int DEGREE_W   = 5;
	parameter int MAX_DEGREE = 16;
	parameter int EDGE_CNT_W = 32;

	////////////////////
	// Array tags
	////////////////////

	// Travels with every read command and read response
	typedef enum logic [0:0] {
		EDGE_ARRAY  = 1'b0,
		LABEL_ARRAY = 1'b1
	} array_tag_t;

	////////////////////
	// Jobs and commands
	////////////////////

	// One vertex job, 53 bits
	typedef struct packed {
		logic [VERTEX_W-1:0] vertex_id;
		logic [ADDR_W-1:0]   edge_start;
		logic [DEGREE_W-1:0] degree;
		logic [LABEL_W-1:0]  label;
	} vertex_job_t;

	// One read command, 17 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		array_tag_t        tag;
	} read_cmd_t;

endpackage

`default_nettype wire

// ==== design/cc_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_sync_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 8
) (
	input  logic   clock,
	input  logic   rstn,
	input  logic   push,
	input  entry_t data_in,
	input  logic   pop,
	output entry_t data_out,
	output logic   empty,
	output logic   full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t           mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Ignore push while full and pop while empty
	assign do_push  = push & ~full;
	assign do_pop   = pop & ~empty;
	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(DEPTH));
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

endmodule

`default_nettype wire

// ==== design/cc_vertex_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_vertex_control import cc_pkg::*; #(
	parameter int VERTEX_FIFO_DEPTH = 16
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                vertex_job_valid,
	input  vertex_job_t         vertex_job,
	output logic                vertex_job_request,
	output logic                vertex_start,
	output vertex_job_t         current_job,
	output logic                edge_cmd_valid,
	output read_cmd_t           edge_cmd,
	input  logic                edge_cmd_ready,
	input  logic                vertex_done,
	output logic [VERTEX_W-1:0] vertex_count
);

	vertex_job_t         fifo_job;
	logic                fifo_empty;
	logic                job_pop;
	logic                processing;
	logic [ADDR_W-1:0]   edge_idx;
	logic [DEGREE_W-1:0] edges_left;

	////////////////////
	// Vertex job buffer
	////////////////////

	cc_sync_fifo #(
		.entry_t(vertex_job_t),
		.DEPTH  (VERTEX_FIFO_DEPTH)
	) vertex_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_job_valid),
		.data_in (vertex_job),
		.pop     (job_pop),
		.data_out(fifo_job),
		.empty   (fifo_empty),
		.full    ()
	);

	// Take a new vertex only when idle
	assign job_pop = ~fifo_empty & ~processing;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_job_request <= 1'b0;
			processing         <= 1'b0;
			vertex_start       <= 1'b0;
			vertex_count       <= '0;
		end else begin
			// Stop asking while the buffer holds anything
			vertex_job_request <= fifo_empty;
			vertex_start       <= job_pop;
			if (job_pop) begin
				processing <= 1'b1;
			end else if (vertex_done) begin
				processing   <= 1'b0;
				vertex_count <= vertex_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (job_pop) begin
			current_job <= fifo_job;
		end
	end

	////////////////////
	// Edge array reads
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			edge_cmd_valid <= 1'b0;
			edge_idx       <= '0;
			edges_left     <= '0;
		end else if (vertex_start) begin
			edge_idx       <= current_job.edge_start;
			edges_left     <= current_job.degree;
			edge_cmd_valid <= (current_job.degree != '0);
		end else if (edge_cmd_valid && edge_cmd_ready) begin
			edge_idx   <= edge_idx + 1'b1;
			edges_left <= edges_left - 1'b1;
			// Last edge of this vertex accepted
			if (edges_left == DEGREE_W'(1)) begin
				edge_cmd_valid <= 1'b0;
			end
		end
	end

	assign edge_cmd.addr = edge_idx;
	assign edge_cmd.tag  = EDGE_ARRAY;

endmodule

`default_nettype wire

// ==== design/cc_edge_data_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_edge_data_reader import cc_pkg::*; #(
	parameter int LABEL_CMD_DEPTH = 16
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              read_resp_valid,
	input  array_tag_t        read_resp_tag,
	input  logic [ADDR_W-1:0] read_resp_data,
	output logic              label_cmd_valid,
	output read_cmd_t         label_cmd,
	input  logic              label_cmd_ready
);

	read_cmd_t new_cmd;
	logic      edge_resp;
	logic      buf_empty;

	// Only edge array responses belong here
	assign edge_resp = read_resp_valid & (read_resp_tag == EDGE_ARRAY);

	// Neighbor id becomes the label array index
	assign new_cmd.addr = read_resp_data;
	assign new_cmd.tag  = LABEL_ARRAY;

	cc_sync_fifo #(
		.entry_t(read_cmd_t),
		.DEPTH  (LABEL_CMD_DEPTH)
	) label_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_resp),
		.data_in (new_cmd),
		.pop     (label_cmd_valid & label_cmd_ready),
		.data_out(label_cmd),
		.empty   (buf_empty),
		.full    ()
	);

	// Offer whenever a command is buffered
	assign label_cmd_valid = ~buf_empty;

endmodule

`default_nettype wire

// ==== design/cc_read_cmd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_read_cmd_arbiter import cc_pkg::*; #(
	parameter int CMD_FIFO_DEPTH = 8
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              edge_cmd_valid,
	input  read_cmd_t         edge_cmd,
	output logic              edge_cmd_ready,
	input  logic              label_cmd_valid,
	input  read_cmd_t         label_cmd,
	output logic              label_cmd_ready,
	output logic              read_cmd_bus_request,
	input  logic              read_cmd_bus_grant,
	output logic              read_cmd_valid,
	output logic [ADDR_W-1:0] read_cmd_addr,
	output array_tag_t        read_cmd_tag
);

	logic      last_was_edge;
	logic      pick_label;
	logic      cmd_push;
	logic      cmd_pop;
	read_cmd_t winner;
	read_cmd_t head;
	logic      cmd_empty;
	logic      cmd_full;

	////////////////////
	// Round robin
	////////////////////

	// Label side wins alone, or on a tie after an edge win
	assign pick_label      = label_cmd_valid & (~edge_cmd_valid | last_was_edge);
	assign edge_cmd_ready  = ~cmd_full & ~pick_label;
	assign label_cmd_ready = ~cmd_full & pick_label;
	assign cmd_push        = ~cmd_full & (edge_cmd_valid | label_cmd_valid);
	assign winner          = pick_label ? label_cmd : edge_cmd;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			last_was_edge <= 1'b0;
		end else if (cmd_push) begin
			last_was_edge <= ~pick_label;
		end
	end

	cc_sync_fifo #(
		.entry_t(read_cmd_t),
		.DEPTH  (CMD_FIFO_DEPTH)
	) burst_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in (winner),
		.pop     (cmd_pop),
		.data_out(head),
		.empty   (cmd_empty),
		.full    (cmd_full)
	);

	////////////////////
	// Bus side
	////////////////////

	// A grant with nothing buffered is dropped
	assign cmd_pop = read_cmd_bus_grant & ~cmd_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			read_cmd_bus_request <= 1'b0;
			read_cmd_valid       <= 1'b0;
		end else begin
			read_cmd_bus_request <= ~cmd_empty;
			read_cmd_valid       <= cmd_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (cmd_pop) begin
			read_cmd_addr <= head.addr;
			read_cmd_tag  <= head.tag;
		end
	end

endmodule

`default_nettype wire

// ==== design/cc_min_label_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_min_label_kernel import cc_pkg::*; (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  vertex_start,
	input  vertex_job_t           current_job,
	input  logic                  read_resp_valid,
	input  array_tag_t            read_resp_tag,
	input  logic [LABEL_W-1:0]    read_resp_data,
	output logic                  label_write_valid,
	output logic [VERTEX_W-1:0]   label_write_vertex,
	output logic [LABEL_W-1:0]    label_write_label,
	output logic                  vertex_done,
	output logic [EDGE_CNT_W-1:0] edge_count
);

	logic                active;
	logic                label_hit;
	logic                finish;
	logic [DEGREE_W-1:0] degree_q;
	logic [DEGREE_W-1:0] resp_count;
	logic [VERTEX_W-1:0] vertex_q;
	logic [LABEL_W-1:0]  min_label;

	assign label_hit = active & read_resp_valid & (read_resp_tag == LABEL_ARRAY);

	// All neighbor labels seen, covers degree zero as well
	assign finish = active & (resp_count == degree_q);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			active     <= 1'b0;
			resp_count <= '0;
			edge_count <= '0;
		end else begin
			if (vertex_start) begin
				active     <= 1'b1;
				resp_count <= '0;
			end else if (finish) begin
				active <= 1'b0;
			end else if (label_hit) begin
				resp_count <= resp_count + 1'b1;
			end
			if (label_hit) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	// Running minimum starts at the own label
	always_ff @(posedge clock) begin
		if (vertex_start) begin
			degree_q  <= current_job.degree;
			vertex_q  <= current_job.vertex_id;
			min_label <= current_job.label;
		end else if (label_hit && (read_resp_data < min_label)) begin
			min_label <= read_resp_data;
		end
	end

	assign label_write_valid  = finish;
	assign label_write_vertex = vertex_q;
	assign label_write_label  = min_label;
	assign vertex_done        = finish;

endmodule

`default_nettype wire

// ==== design/cc_compute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_compute_unit import cc_pkg::*; #(
	parameter int VERTEX_FIFO_DEPTH = 16,
	parameter int CMD_FIFO_DEPTH    = 8,
	parameter int LABEL_CMD_DEPTH   = MAX_DEGREE
) (
	input  logic                  clock,
	input  logic                  rstn,
	// Vertex jobs from the scheduler
	input  logic                  vertex_job_valid,
	input  vertex_job_t           vertex_job,
	output logic                  vertex_job_request,
	// Read command bus
	output logic                  read_cmd_bus_request,
	input  logic                  read_cmd_bus_grant,
	output logic                  read_cmd_valid,
	output logic [ADDR_W-1:0]     read_cmd_addr,
	output array_tag_t            read_cmd_tag,
	// Read responses
	input  logic                  read_resp_valid,
	input  array_tag_t            read_resp_tag,
	input  logic [LABEL_W-1:0]    read_resp_data,
	// Label writes
	output logic                  label_write_valid,
	output logic [VERTEX_W-1:0]   label_write_vertex,
	output logic [LABEL_W-1:0]    label_write_label,
	// Status
	output logic [VERTEX_W-1:0]   vertex_count,
	output logic [EDGE_CNT_W-1:0] edge_count
);

	logic        vertex_start;
	vertex_job_t current_job;
	logic        vertex_done;
	logic        edge_cmd_valid;
	read_cmd_t   edge_cmd;
	logic        edge_cmd_ready;
	logic        label_cmd_valid;
	read_cmd_t   label_cmd;
	logic        label_cmd_ready;

	////////////////////
	// Control
	////////////////////

	cc_vertex_control #(
		.VERTEX_FIFO_DEPTH(VERTEX_FIFO_DEPTH)
	) vertex_control (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_job_valid  (vertex_job_valid),
		.vertex_job        (vertex_job),
		.vertex_job_request(vertex_job_request),
		.vertex_start      (vertex_start),
		.current_job       (current_job),
		.edge_cmd_valid    (edge_cmd_valid),
		.edge_cmd          (edge_cmd),
		.edge_cmd_ready    (edge_cmd_ready),
		.vertex_done       (vertex_done),
		.vertex_count      (vertex_count)
	);

	////////////////////
	// Datapath
	////////////////////

	cc_edge_data_reader #(
		.LABEL_CMD_DEPTH(LABEL_CMD_DEPTH)
	) edge_data_reader (
		.clock          (clock),
		.rstn           (rstn),
		.read_resp_valid(read_resp_valid),
		.read_resp_tag  (read_resp_tag),
		.read_resp_data (read_resp_data),
		.label_cmd_valid(label_cmd_valid),
		.label_cmd      (label_cmd),
		.label_cmd_ready(label_cmd_ready)
	);

	// Both command sources share one bus request
	cc_read_cmd_arbiter #(
		.CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
	) read_cmd_arbiter (
		.clock               (clock),
		.rstn                (rstn),
		.edge_cmd_valid      (edge_cmd_valid),
		.edge_cmd            (edge_cmd),
		.edge_cmd_ready      (edge_cmd_ready),
		.label_cmd_valid     (label_cmd_valid),
		.label_cmd           (label_cmd),
		.label_cmd_ready     (label_cmd_ready),
		.read_cmd_bus_request(read_cmd_bus_request),
		.read_cmd_bus_grant  (read_cmd_bus_grant),
		.read_cmd_valid      (read_cmd_valid),
		.read_cmd_addr       (read_cmd_addr),
		.read_cmd_tag        (read_cmd_tag)
	);

	cc_min_label_kernel min_label_kernel (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_start      (vertex_start),
		.current_job       (current_job),
		.read_resp_valid   (read_resp_valid),
		.read_resp_tag     (read_resp_tag),
		.read_resp_data    (read_resp_data),
		.label_write_valid (label_write_valid),
		.label_write_vertex(label_write_vertex),
		.label_write_label (label_write_label),
		.vertex_done       (vertex_done),
		.edge_count        (edge_count)
	);

endmodule

`default_nettype wire

// ==== verification/cc_tb_functions.svh ====
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// Neighbor id stored at edge index i, limited to 256 vertices
function automatic logic [15:0] edge_value(input logic [15:0] i);
	logic [31:0] x;
	x = xorshift32({16'h0, i} ^ 32'he5836656);
	return {8'h00, x[7:0]};
endfunction

// Label stored for vertex v
function automatic logic [15:0] label_value(input logic [15:0] v);
	logic [31:0] x;
	x = xorshift32({v, 16'h0} ^ 32'h2545f491);
	return x[15:0];
endfunction

// ==== verification/cc_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_memory_model import cc_pkg::*; #(
	parameter logic [31:0] SEED = 32'h1
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               read_cmd_valid,
	input  logic [ADDR_W-1:0]  read_cmd_addr,
	input  array_tag_t         read_cmd_tag,
	output logic               read_resp_valid,
	output array_tag_t         read_resp_tag,
	output logic [LABEL_W-1:0] read_resp_data
);

	`include "cc_tb_functions.svh"

	logic [31:0]       rng_state;
	int                cycle;
	int                due_q[$];
	logic [ADDR_W-1:0] addr_q[$];
	array_tag_t        tag_q[$];

	initial begin
		read_resp_valid = 1'b0;
		read_resp_tag   = EDGE_ARRAY;
		read_resp_data  = '0;
		rng_state       = SEED;
		cycle           = 0;
	end

	// Commands wait 1 to 4 cycles, one response per cycle
	always @(posedge clock) begin
		logic [ADDR_W-1:0] addr;
		array_tag_t        tag;
		if (!rstn) begin
			due_q.delete();
			addr_q.delete();
			tag_q.delete();
			#1;
			read_resp_valid = 1'b0;
		end else begin
			cycle++;
			if (read_cmd_valid) begin
				rng_state = xorshift32(rng_state);
				due_q.push_back(cycle + 1 + int'(rng_state % 4));
				addr_q.push_back(read_cmd_addr);
				tag_q.push_back(read_cmd_tag);
			end
			#1;
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				void'(due_q.pop_front());
				addr = addr_q.pop_front();
				tag  = tag_q.pop_front();
				read_resp_valid = 1'b1;
				read_resp_tag   = tag;
				read_resp_data  = (tag == EDGE_ARRAY) ? edge_value(addr) : label_value(addr);
			end else begin
				read_resp_valid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/cc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cc_tb import cc_pkg::*; ();

	`include "cc_tb_functions.svh"

	localparam int WAIT_LIMIT = 4000;

	logic                  clock;
	logic                  rstn;
	logic                  vertex_job_valid;
	vertex_job_t           vertex_job;
	logic                  vertex_job_request;
	logic                  read_cmd_bus_request;
	logic                  read_cmd_bus_grant;
	logic                  read_cmd_valid;
	logic [ADDR_W-1:0]     read_cmd_addr;
	array_tag_t            read_cmd_tag;
	logic                  read_resp_valid;
	array_tag_t            read_resp_tag;
	logic [LABEL_W-1:0]    read_resp_data;
	logic                  label_write_valid;
	logic [VERTEX_W-1:0]   label_write_vertex;
	logic [LABEL_W-1:0]    label_write_label;
	logic [VERTEX_W-1:0]   vertex_count;
	logic [EDGE_CNT_W-1:0] edge_count;

	logic [31:0]        rng_state;
	logic [31:0]        grant_state;
	int                 errors;
	int                 checks;
	int                 writes_seen;
	int                 edge_cmds;
	int                 read_cmds;
	int                 returned_ids[256];
	int                 next_edge;
	int                 degree_sum;
	int                 cmds_before;
	vertex_job_t        pending[$];
	vertex_job_t        batch_q[$];
	logic [LABEL_W-1:0] exp_label[int];
	vertex_job_t        job;

	cc_compute_unit DUT (.*);

	cc_memory_model #(.SEED(32'he5836656)) memory (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Expected label: own label against every neighbor label
	function automatic logic [LABEL_W-1:0] ref_min_label(input vertex_job_t j);
		logic [LABEL_W-1:0] best;
		logic [LABEL_W-1:0] lbl;
		int                 i;
		best = j.label;
		for (i = 0; i < int'(j.degree); i++) begin
			lbl = label_value(edge_value(j.edge_start + ADDR_W'(i)));
			if (lbl < best) best = lbl;
		end
		return best;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic apply_reset();
		rstn = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		pending.delete();
		exp_label.delete();
		foreach (returned_ids[i]) returned_ids[i] = 0;
		writes_seen = 0;
		edge_cmds   = 0;
		read_cmds   = 0;
		rstn = 1'b1;
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		while (!vertex_job_request && n < WAIT_LIMIT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (!vertex_job_request) report_timeout("vertex job request");
	endtask

	task automatic wait_writes(input int target);
		int n;
		n = 0;
		while (writes_seen < target && n < WAIT_LIMIT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (writes_seen < target) report_timeout("label writes");
	endtask

	task automatic make_job(input int id, input int degree, input logic [LABEL_W-1:0] lbl);
		job.vertex_id  = VERTEX_W'(id);
		job.edge_start = ADDR_W'(next_edge);
		job.degree     = DEGREE_W'(degree);
		job.label      = lbl;
		next_edge += degree;
		degree_sum += degree;
		batch_q.push_back(job);
	endtask

	// Push the whole batch back to back once the FIFO asks for work
	task automatic send_batch();
		vertex_job_t j;
		wait_request();
		while (batch_q.size() > 0) begin
			j = batch_q.pop_front();
			pending.push_back(j);
			exp_label[int'(j.vertex_id)] = ref_min_label(j);
			vertex_job_valid = 1'b1;
			vertex_job       = j;
			@(posedge clock);
			#1;
		end
		vertex_job_valid = 1'b0;
		// Request is one cycle stale after a push
		repeat (2) @(posedge clock);
		#1;
	endtask

	////////////////////
	// Monitors
	////////////////////

	// Random bus grants
	initial begin
		grant_state = xorshift32(32'he5836656);
		read_cmd_bus_grant = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			grant_state = xorshift32(grant_state);
			read_cmd_bus_grant = read_cmd_bus_request & (grant_state[1:0] != 2'b00);
		end
	end

	// Read commands against the edge range and returned neighbor ids
	always @(posedge clock) begin
		vertex_job_t cur;
		if (rstn) begin
			if (read_resp_valid && read_resp_tag == EDGE_ARRAY && read_resp_data < 256) begin
				returned_ids[read_resp_data]++;
			end
			if (read_cmd_valid) begin
				read_cmds++;
				if (read_cmd_tag == EDGE_ARRAY) begin
					edge_cmds++;
					if (pending.size() == 0) begin
						errors++;
						$display("Edge read at index %0d while no job is pending", read_cmd_addr);
					end else begin
						cur = pending[0];
						if (read_cmd_addr < cur.edge_start ||
						    int'(read_cmd_addr) >= int'(cur.edge_start) + int'(cur.degree)) begin
							errors++;
							$display("Edge read at index %0d outside the range of vertex %0d",
							         read_cmd_addr, cur.vertex_id);
						end
					end
				end else if (read_cmd_addr > 255 || returned_ids[read_cmd_addr[7:0]] == 0) begin
					errors++;
					$display("Label read of vertex %0d that no edge response returned",
					         read_cmd_addr);
				end else begin
					returned_ids[read_cmd_addr[7:0]]--;
				end
			end
		end
	end

	// Label writes against the reference
	always @(posedge clock) begin
		vertex_job_t head;
		if (rstn && label_write_valid) begin
			writes_seen++;
			if (!exp_label.exists(int'(label_write_vertex))) begin
				errors++;
				$display("Label write for vertex %0d which has no pending job", label_write_vertex);
			end else begin
				check_value("label_write_label", label_write_label,
				            exp_label[int'(label_write_vertex)]);
				exp_label.delete(int'(label_write_vertex));
			end
			if (pending.size() > 0) begin
				head = pending.pop_front();
				check_value("label_write_vertex", label_write_vertex, head.vertex_id);
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int i;
		int left;
		int n;
		rng_state        = 32'he5836656;
		errors           = 0;
		checks           = 0;
		next_edge        = 0;
		degree_sum       = 0;
		vertex_job_valid = 1'b0;
		vertex_job       = '0;
		apply_reset();

		// State right after reset
		repeat (2) @(posedge clock);
		#1;
		check_value("read_cmd_bus_request", read_cmd_bus_request, 0);
		check_value("read_cmd_valid", read_cmd_valid, 0);
		check_value("label_write_valid", label_write_valid, 0);
		check_value("vertex_count", vertex_count, 0);
		check_value("edge_count", edge_count, 0);
		check_value("vertex_job_request", vertex_job_request, 1);

		// One vertex of degree 4
		make_job(1, 4, 16'hffff);
		send_batch();
		wait_writes(1);
		repeat (10) @(posedge clock);
		#1;
		check_value("label write count", writes_seen, 1);

		// Own label below all neighbors
		make_job(2, 5, 16'h0000);
		send_batch();
		wait_writes(2);

		// Degree zero issues no reads
		cmds_before = read_cmds;
		make_job(3, 0, 16'h1234);
		send_batch();
		wait_writes(3);
		repeat (20) @(posedge clock);
		#1;
		check_value("read command count", read_cmds, cmds_before);

		// Forty random jobs from a fresh reset
		apply_reset();
		degree_sum = 0;
		left = 40;
		i = 100;
		while (left > 0) begin
			n = 1 + int'(next_rand() % 8);
			if (n > left) n = left;
			repeat (n) begin
				make_job(i, int'(next_rand() % (MAX_DEGREE + 1)), LABEL_W'(next_rand()));
				i++;
			end
			left -= n;
			send_batch();
		end
		wait_writes(40);
		repeat (3) @(posedge clock);
		#1;
		check_value("vertex_count", vertex_count, 40);
		check_value("edge_count", edge_count, degree_sum);
		check_value("edge read count", edge_cmds, degree_sum);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verification
design/cc_pkg.sv
design/cc_sync_fifo.sv
design/cc_vertex_control.sv
design/cc_edge_data_reader.sv
design/cc_read_cmd_arbiter.sv
design/cc_min_label_kernel.sv
design/cc_compute_unit.sv
verification/cc_memory_model.sv
verification/cc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cc_tb -f all.f -o cc_sim \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/cc_sim > sim.log 2>&1 || { echo "Simulation error, see sim.log"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"
